/* decodeStage.sv */
module decodeStage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      freeze,
    input  logic                      branchTaken,
    fetchLink.dst                     fromFetch,
    wbLink.dst                        wb,
    execLink.src                      toExec,
    output logic                      jumpTaken,
    output logic                      loadStall,
    output logic [pipePkg::dataW-1:0] jumpTarget
);

    isaPkg::instrWord          ins;
    logic [pipePkg::dataW-1:0] regs [32];
    logic [2:0]                aluOp;
    logic                      useImm;
    logic                      useRd;
    logic                      regWrite;
    logic                      memRead;
    logic                      memWrite;
    logic                      isBranch;
    logic                      isJump;

    assign ins = fromFetch.instr;

    ////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////

    always_comb begin
        aluOp    = pipePkg::aluAdd;
        useImm   = 1'b0;
        useRd    = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        case (ins.r.opcode)
            isaPkg::opR: begin
                useRd    = 1'b1;
                regWrite = 1'b1;
                case (ins.r.funct)
                    isaPkg::fnAdd: aluOp = pipePkg::aluAdd;
                    isaPkg::fnSub: aluOp = pipePkg::aluSub;
                    isaPkg::fnAnd: aluOp = pipePkg::aluAnd;
                    isaPkg::fnOr:  aluOp = pipePkg::aluOr;
                    isaPkg::fnSlt: aluOp = pipePkg::aluSlt;
                    // unknown funct is a no-op
                    default: regWrite = 1'b0;
                endcase
            end
            isaPkg::opAddi: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            isaPkg::opLw: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            isaPkg::opSw: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            isaPkg::opBeq: begin
                aluOp    = pipePkg::aluSub;
                isBranch = 1'b1;
            end
            isaPkg::opJ: isJump = 1'b1;
            default: ;
        endcase
    end

    // load in execute feeding this instruction
    assign loadStall = toExec.memRead && (toExec.wsel != '0) &&
                       ((toExec.wsel == ins.i.rs) || (toExec.wsel == ins.i.rt));

    // a stalled jump waits until decode moves on
    assign jumpTaken  = isJump && !loadStall;
    assign jumpTarget = {fromFetch.pcPlus4[31:28], ins.i.rs, ins.i.rt, ins.i.imm16, 2'b00};

    ////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!freeze && wb.regWrite && (wb.wsel != '0)) begin
            regs[wb.wsel] <= wb.wdata;
        end
    end

    // write-through so writeback and decode meet in one cycle
    function automatic logic [pipePkg::dataW-1:0] readReg(input logic [4:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.regWrite && (wb.wsel == idx)) begin
            return wb.wdata;
        end
        return regs[idx];
    endfunction

    ////////////////////////////////////////////////
    // decode/execute register
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toExec.regWrite <= 1'b0;
            toExec.memRead  <= 1'b0;
            toExec.memWrite <= 1'b0;
            toExec.isBranch <= 1'b0;
        end else if (!freeze) begin
            // bubble on taken branch or load-use
            toExec.regWrite <= regWrite && !branchTaken && !loadStall;
            toExec.memRead  <= memRead && !branchTaken && !loadStall;
            toExec.memWrite <= memWrite && !branchTaken && !loadStall;
            toExec.isBranch <= isBranch && !branchTaken && !loadStall;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            toExec.aluOp   <= aluOp;
            toExec.useImm  <= useImm;
            toExec.opA     <= readReg(ins.i.rs);
            toExec.opB     <= readReg(ins.i.rt);
            toExec.imm     <= {{16{ins.i.imm16[15]}}, ins.i.imm16};
            toExec.rs      <= ins.i.rs;
            toExec.rt      <= ins.i.rt;
            toExec.wsel    <= useRd ? ins.r.rd : ins.i.rt;
            toExec.pcPlus4 <= fromFetch.pcPlus4;
        end
    end

endmodule

/* executeStage.sv */
module executeStage (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  freeze,
    execLink.dst  fromDecode,
    wbLink.dst    wb,
    memLink.src   toMem,
    branchLink.src branch
);

    logic [1:0]                selA;
    logic [1:0]                selB;
    logic [pipePkg::dataW-1:0] fwdA;
    logic [pipePkg::dataW-1:0] fwdB;
    logic [pipePkg::dataW-1:0] aluB;
    logic [pipePkg::dataW-1:0] aluY;

    ////////////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////////////

    // memory stage is the younger producer
    function automatic logic [1:0] pickFwd(input logic [isaPkg::regIdxW-1:0] src);
        if (src == '0) begin
            return pipePkg::fwdReg;
        end
        if (toMem.regWrite && (toMem.wsel == src)) begin
            return pipePkg::fwdMem;
        end
        if (wb.regWrite && (wb.wsel == src)) begin
            return pipePkg::fwdWb;
        end
        return pipePkg::fwdReg;
    endfunction

    function automatic logic [pipePkg::dataW-1:0] fwdValue(
        input logic [1:0]                sel,
        input logic [pipePkg::dataW-1:0] regVal
    );
        case (sel)
            pipePkg::fwdMem: return toMem.aluResult;
            pipePkg::fwdWb:  return wb.wdata;
            default:         return regVal;
        endcase
    endfunction

    assign selA = pickFwd(fromDecode.rs);
    assign selB = pickFwd(fromDecode.rt);
    assign fwdA = fwdValue(selA, fromDecode.opA);
    assign fwdB = fwdValue(selB, fromDecode.opB);
    assign aluB = fromDecode.useImm ? fromDecode.imm : fwdB;

    ////////////////////////////////////////////////
    // alu and branch
    ////////////////////////////////////////////////

    always_comb begin
        case (fromDecode.aluOp)
            pipePkg::aluSub: aluY = fwdA - aluB;
            pipePkg::aluAnd: aluY = fwdA & aluB;
            pipePkg::aluOr:  aluY = fwdA | aluB;
            pipePkg::aluSlt: aluY = {31'd0, $signed(fwdA) < $signed(aluB)};
            default:         aluY = fwdA + aluB;
        endcase
    end

    assign branch.branchTaken  = fromDecode.isBranch && (fwdA == fwdB);
    assign branch.branchTarget = fromDecode.pcPlus4 +
                                 {fromDecode.imm[pipePkg::dataW-3:0], 2'b00};

    ////////////////////////////////////////////////
    // execute/memory register
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toMem.regWrite <= 1'b0;
            toMem.memRead  <= 1'b0;
            toMem.memWrite <= 1'b0;
        end else if (!freeze) begin
            toMem.regWrite <= fromDecode.regWrite;
            toMem.memRead  <= fromDecode.memRead;
            toMem.memWrite <= fromDecode.memWrite;
        end
    end

    // store data is rt after forwarding
    always_ff @(posedge clk) begin
        if (!freeze) begin
            toMem.aluResult <= aluY;
            toMem.storeData <= fwdB;
            toMem.wsel      <= fromDecode.wsel;
        end
    end

endmodule

/* files.f */
+incdir+.
isaPkg.sv
pipePkg.sv
pipeLinks.sv
instrFetch.sv
decodeStage.sv
executeStage.sv
memWriteback.sv
mipsPipeline.sv
mipsPipelineTb.sv

/* instrFetch.sv */
module instrFetch (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          freeze,
    input  logic                          loadStall,
    input  logic                          jumpTaken,
    input  logic [pipePkg::dataW-1:0]     jumpTarget,
    branchLink.dst                        branch,
    fetchLink.src                         toDecode,
    output logic [pipePkg::wordAddrW-1:0] icacheAddr,
    input  logic [pipePkg::dataW-1:0]     icacheRdata
);

    logic [pipePkg::dataW-1:0] pc;
    logic [pipePkg::dataW-1:0] pcPlus4;
    logic [pipePkg::dataW-1:0] nextPc;

    ////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////

    assign pcPlus4 = pc + 'd4;

    // branch in execute is older than a jump in decode
    always_comb begin
        if (branch.branchTaken) begin
            nextPc = branch.branchTarget;
        end else if (jumpTaken) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!freeze && !loadStall) begin
            pc <= nextPc;
        end
    end

    assign icacheAddr = pc[pipePkg::dataW-1:2];

    ////////////////////////////////////////////////
    // fetch/decode register
    ////////////////////////////////////////////////

    // all-zero word decodes as a no-op
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toDecode.instr <= '0;
        end else if (!freeze) begin
            if (branch.branchTaken || jumpTaken) begin
                toDecode.instr <= '0;
            end else if (!loadStall) begin
                toDecode.instr <= icacheRdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !loadStall) begin
            toDecode.pcPlus4 <= pcPlus4;
        end
    end

endmodule

/* isaPkg.sv */
package isaPkg;

    ////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////

    localparam int regIdxW = 5;

    // opcodes of the kept subset
    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSw   = 6'h2b;

    // funct codes under opR
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    ////////////////////////////////////////////////
    // one word, two decodings
    ////////////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [5:0]         opcode;
            logic [regIdxW-1:0] rs;
            logic [regIdxW-1:0] rt;
            logic [regIdxW-1:0] rd;
            logic [4:0]         shamt;
            logic [5:0]         funct;
        } r;
        // jump target is the low 26 bits of this view
        struct packed {
            logic [5:0]         opcode;
            logic [regIdxW-1:0] rs;
            logic [regIdxW-1:0] rt;
            logic [15:0]        imm16;
        } i;
    } instrWord;

endpackage

/* memWriteback.sv */
module memWriteback (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          freeze,
    memLink.dst                           fromExec,
    wbLink.src                            wb,
    output logic                          dcacheRen,
    output logic                          dcacheWen,
    output logic [pipePkg::wordAddrW-1:0] dcacheAddr,
    output logic [pipePkg::dataW-1:0]     dcacheWdata,
    input  logic [pipePkg::dataW-1:0]     dcacheRdata
);

    logic                      wbSel;
    logic [pipePkg::dataW-1:0] loadData;
    logic [pipePkg::dataW-1:0] aluResult;

    // data cache straight from the memory-stage fields
    assign dcacheRen   = fromExec.memRead;
    assign dcacheWen   = fromExec.memWrite;
    assign dcacheAddr  = fromExec.aluResult[pipePkg::dataW-1:2];
    assign dcacheWdata = fromExec.storeData;

    ////////////////////////////////////////////////
    // memory/writeback register
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.regWrite <= 1'b0;
            wbSel       <= pipePkg::wbAlu;
        end else if (!freeze) begin
            wb.regWrite <= fromExec.regWrite;
            wbSel       <= fromExec.memRead ? pipePkg::wbMem : pipePkg::wbAlu;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            wb.wsel   <= fromExec.wsel;
            loadData  <= dcacheRdata;
            aluResult <= fromExec.aluResult;
        end
    end

    assign wb.wdata = (wbSel == pipePkg::wbMem) ? loadData : aluResult;

endmodule

/* mipsPipeline.sv */
module mipsPipeline (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          icacheRen,
    output logic                          icacheWen,
    output logic [pipePkg::wordAddrW-1:0] icacheAddr,
    output logic [pipePkg::dataW-1:0]     icacheWdata,
    input  logic                          icacheStall,
    input  logic [pipePkg::dataW-1:0]     icacheRdata,
    output logic                          dcacheRen,
    output logic                          dcacheWen,
    output logic [pipePkg::wordAddrW-1:0] dcacheAddr,
    output logic [pipePkg::dataW-1:0]     dcacheWdata,
    input  logic                          dcacheStall,
    input  logic [pipePkg::dataW-1:0]     dcacheRdata
);

    logic                      freeze;
    logic                      loadStall;
    logic                      jumpTaken;
    logic [pipePkg::dataW-1:0] jumpTarget;

    fetchLink  fetchBus ();
    branchLink branchBus ();
    execLink   execBus ();
    memLink    memBus ();
    wbLink     wbBus ();

    // either cache stalling holds the whole pipe
    assign freeze = icacheStall | dcacheStall;

    // instruction cache is read-only
    assign icacheRen   = 1'b1;
    assign icacheWen   = 1'b0;
    assign icacheWdata = '0;

    instrFetch instrFetch_inst (
        .clk(clk), .rst_n(rst_n), .freeze(freeze),
        .loadStall(loadStall), .jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
        .branch(branchBus), .toDecode(fetchBus),
        .icacheAddr(icacheAddr), .icacheRdata(icacheRdata)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .rst_n(rst_n), .freeze(freeze),
        .branchTaken(branchBus.branchTaken),
        .fromFetch(fetchBus), .wb(wbBus), .toExec(execBus),
        .jumpTaken(jumpTaken), .loadStall(loadStall), .jumpTarget(jumpTarget)
    );

    executeStage executeStage_inst (
        .clk(clk), .rst_n(rst_n), .freeze(freeze),
        .fromDecode(execBus), .wb(wbBus), .toMem(memBus), .branch(branchBus)
    );

    memWriteback memWriteback_inst (
        .clk(clk), .rst_n(rst_n), .freeze(freeze),
        .fromExec(memBus), .wb(wbBus),
        .dcacheRen(dcacheRen), .dcacheWen(dcacheWen), .dcacheAddr(dcacheAddr),
        .dcacheWdata(dcacheWdata), .dcacheRdata(dcacheRdata)
    );

endmodule

/* tbIsaModel.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// words in the program image, closing j-to-self included
localparam int progLen = 36;

logic [31:0] refMem [64];
logic [29:0] expAddr [$];
logic [31:0] expData [$];
logic [29:0] expLoad [$];

// preload value, every address bit takes part
function automatic logic [31:0] dataPattern(input int idx);
    return 32'h5a3c_0f00 ^ (idx * 32'h0101_0101);
endfunction

function automatic logic [31:0] rWord(input logic [5:0] fn, input int rd, input int rs,
                                      input int rt);
    isaPkg::instrWord w;
    w.r.opcode = isaPkg::opR;
    w.r.rs     = rs[4:0];
    w.r.rt     = rt[4:0];
    w.r.rd     = rd[4:0];
    w.r.shamt  = '0;
    w.r.funct  = fn;
    return w;
endfunction

function automatic logic [31:0] iWord(input logic [5:0] op, input int rt, input int rs,
                                      input int imm);
    isaPkg::instrWord w;
    w.i.opcode = op;
    w.i.rs     = rs[4:0];
    w.i.rt     = rt[4:0];
    w.i.imm16  = imm[15:0];
    return w;
endfunction

// target field is the low 26 bits of the i view
function automatic logic [31:0] jumpWord(input int target);
    isaPkg::instrWord w;
    w.i.opcode                     = isaPkg::opJ;
    {w.i.rs, w.i.rt, w.i.imm16}    = target[27:2];
    return w;
endfunction

task automatic loadProgram();
    for (int i = 0; i < 64; i++) begin
        imem[i] = '0;
    end
    imem[0]  = iWord(isaPkg::opAddi, 1, 0, 7);
    imem[1]  = iWord(isaPkg::opAddi, 2, 0, -3);
    // r2 from memory stage, r1 from writeback
    imem[2]  = rWord(isaPkg::fnAdd, 3, 1, 2);
    imem[3]  = iWord(isaPkg::opSw, 3, 0, 0);
    imem[4]  = rWord(isaPkg::fnSub, 4, 1, 2);
    imem[5]  = iWord(isaPkg::opSw, 4, 0, 4);
    imem[6]  = rWord(isaPkg::fnAnd, 5, 1, 2);
    imem[7]  = iWord(isaPkg::opSw, 5, 0, 8);
    imem[8]  = rWord(isaPkg::fnOr, 6, 1, 2);
    imem[9]  = iWord(isaPkg::opSw, 6, 0, 12);
    imem[10] = rWord(isaPkg::fnSlt, 7, 2, 1);
    imem[11] = rWord(isaPkg::fnSlt, 8, 1, 2);
    imem[12] = iWord(isaPkg::opSw, 7, 0, 16);
    imem[13] = iWord(isaPkg::opSw, 8, 0, 20);
    // load-use through the alu, then through store data
    imem[14] = iWord(isaPkg::opLw, 9, 0, 64);
    imem[15] = rWord(isaPkg::fnAdd, 10, 9, 1);
    imem[16] = iWord(isaPkg::opSw, 10, 0, 24);
    imem[17] = iWord(isaPkg::opLw, 11, 0, 68);
    imem[18] = iWord(isaPkg::opSw, 11, 0, 28);
    imem[19] = iWord(isaPkg::opAddi, 0, 0, 55);
    imem[20] = iWord(isaPkg::opSw, 0, 0, 32);
    // taken beq skips two stores
    imem[21] = iWord(isaPkg::opBeq, 1, 1, 2);
    imem[22] = iWord(isaPkg::opSw, 1, 0, 36);
    imem[23] = iWord(isaPkg::opSw, 2, 0, 36);
    imem[24] = iWord(isaPkg::opBeq, 2, 1, 1);
    imem[25] = iWord(isaPkg::opSw, 1, 0, 40);
    imem[26] = jumpWord(28 * 4);
    imem[27] = iWord(isaPkg::opSw, 2, 0, 44);
    // the younger r12 must win as base
    imem[28] = iWord(isaPkg::opAddi, 12, 0, 48);
    imem[29] = iWord(isaPkg::opAddi, 12, 12, 4);
    imem[30] = iWord(isaPkg::opSw, 1, 12, 0);
    imem[31] = iWord(isaPkg::opLw, 13, 0, 52);
    imem[32] = iWord(isaPkg::opBeq, 13, 1, 1);
    imem[33] = iWord(isaPkg::opSw, 2, 0, 60);
    imem[34] = iWord(isaPkg::opSw, 13, 0, 60);
    imem[35] = jumpWord(35 * 4);
endtask

// runs the program in order and lists its stores
function automatic void runReference();
    logic [31:0]      rf [32];
    logic [31:0]      pc;
    logic [31:0]      nextPc;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      imm;
    logic [31:0]      addr;
    logic [31:0]      result;
    logic [4:0]       dst;
    logic             write;
    logic             halted;
    int               steps;
    isaPkg::instrWord w;
    for (int i = 0; i < 32; i++) begin
        rf[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        refMem[i] = dataPattern(i);
    end
    pc     = '0;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < 1000) begin
        w      = imem[pc[7:2]];
        a      = rf[w.i.rs];
        b      = rf[w.i.rt];
        imm    = {{16{w.i.imm16[15]}}, w.i.imm16};
        addr   = a + imm;
        nextPc = pc + 32'd4;
        write  = 1'b0;
        dst    = w.i.rt;
        result = addr;
        case (w.r.opcode)
            isaPkg::opR: begin
                dst   = w.r.rd;
                write = 1'b1;
                case (w.r.funct)
                    isaPkg::fnAdd: result = a + b;
                    isaPkg::fnSub: result = a - b;
                    isaPkg::fnAnd: result = a & b;
                    isaPkg::fnOr:  result = a | b;
                    isaPkg::fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:       write = 1'b0;
                endcase
            end
            isaPkg::opAddi: write = 1'b1;
            isaPkg::opLw: begin
                write  = 1'b1;
                result = refMem[addr[7:2]];
                expLoad.push_back(addr[31:2]);
            end
            isaPkg::opSw: begin
                refMem[addr[7:2]] = b;
                expAddr.push_back(addr[31:2]);
                expData.push_back(b);
            end
            isaPkg::opBeq: begin
                if (a == b) begin
                    nextPc = nextPc + (imm << 2);
                end
            end
            isaPkg::opJ: begin
                nextPc = {nextPc[31:28], w.i.rs, w.i.rt, w.i.imm16, 2'b00};
                // jump to itself ends the program
                halted = (nextPc == pc);
            end
            default: ;
        endcase
        if (write && dst != '0) begin
            rf[dst] = result;
        end
        pc    = nextPc;
        steps = steps + 1;
    end
endfunction

`endif

/* mipsPipelineTb.sv */
module mipsPipelineTb;

    logic                          clk;
    logic                          rst_n;
    logic                          icacheRen;
    logic                          icacheWen;
    logic [pipePkg::wordAddrW-1:0] icacheAddr;
    logic [pipePkg::dataW-1:0]     icacheWdata;
    logic                          icacheStall = 1'b0;
    logic [pipePkg::dataW-1:0]     icacheRdata;
    logic                          dcacheRen;
    logic                          dcacheWen;
    logic [pipePkg::wordAddrW-1:0] dcacheAddr;
    logic [pipePkg::dataW-1:0]     dcacheWdata;
    logic                          dcacheStall = 1'b0;
    logic [pipePkg::dataW-1:0]     dcacheRdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    integer      seed = 32'hb476_9243;
    int          cycles = 0;
    int          storeIdx = 0;
    int          loadIdx = 0;
    int          mismatches = 0;
    int          otherErrors = 0;

    `include "tbIsaModel.svh"

    localparam int cycleLimit = 20 * progLen + 200;

    mipsPipeline mipsPipeline_inst (.*);

    // both caches answer in the same cycle
    assign icacheRdata = imem[icacheAddr[5:0]];
    assign dcacheRdata = dmem[dcacheAddr[5:0]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // each cache stalls about one cycle in four
    always @(posedge clk) begin
        if (rst_n) begin
            icacheStall <= (($random(seed) & 3) == 0);
            dcacheStall <= (($random(seed) & 3) == 0);
        end
    end

    task automatic closeRun(input bit timedOut);
        $display("errors: %0d mismatches, %0d other, %0d timeout, stores %0d of %0d, %s",
                 mismatches, otherErrors, timedOut, storeIdx, expAddr.size(),
                 $sformatf("loads %0d of %0d", loadIdx, expLoad.size()));
        if (mismatches == 0 && otherErrors == 0 && !timedOut &&
            storeIdx == expAddr.size() && loadIdx == expLoad.size()) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst_n <= 1'b0;
        loadProgram();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = dataPattern(i);
        end
        runReference();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (storeIdx < expAddr.size()) begin
            @(posedge clk);
        end
        // extra cycles so a duplicate store shows up
        repeat (20) @(posedge clk);
        closeRun(1'b0);
    end

    //////////////////////////////////////////////////
    // store checks
    //////////////////////////////////////////////////

    // mid-cycle, all DUT outputs and stalls are settled
    always @(negedge clk) begin
        if (rst_n && icacheWen !== 1'b0) begin
            mismatches++;
            $display("MISMATCH at %0t: icacheWen got %b expected 0", $time, icacheWen);
        end
        if (rst_n && icacheRen !== 1'b1) begin
            mismatches++;
            $display("MISMATCH at %0t: icacheRen got %b expected 1", $time, icacheRen);
        end
        if (rst_n && icacheWdata !== '0) begin
            mismatches++;
            $display("MISMATCH at %0t: icacheWdata got %h expected 0", $time, icacheWdata);
        end
        if (rst_n && dcacheWen && !dcacheStall) begin
            dmem[dcacheAddr[5:0]] <= dcacheWdata;
        end
        // each load is counted once, when the pipe moves
        if (rst_n && dcacheRen && !dcacheStall && !icacheStall) begin
            if (loadIdx >= expLoad.size()) begin
                otherErrors++;
                $display("at %0t an unexpected extra load was seen, address %h",
                         $time, dcacheAddr);
            end else if (dcacheAddr !== expLoad[loadIdx]) begin
                mismatches++;
                $display("MISMATCH at %0t: dcacheAddr got %h expected %h",
                         $time, dcacheAddr, expLoad[loadIdx]);
            end
            loadIdx++;
        end
        // the store only retires when the pipe moves
        if (rst_n && dcacheWen && !dcacheStall && !icacheStall) begin
            if (storeIdx >= expAddr.size()) begin
                otherErrors++;
                $display("at %0t an unexpected extra store was seen, address %h data %h",
                         $time, dcacheAddr, dcacheWdata);
            end else begin
                if (dcacheAddr !== expAddr[storeIdx]) begin
                    mismatches++;
                    $display("MISMATCH at %0t: dcacheAddr got %h expected %h",
                             $time, dcacheAddr, expAddr[storeIdx]);
                end
                if (dcacheWdata !== expData[storeIdx]) begin
                    mismatches++;
                    $display("MISMATCH at %0t: dcacheWdata got %h expected %h",
                             $time, dcacheWdata, expData[storeIdx]);
                end
            end
            storeIdx++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit) begin
            $display("timeout after %0d cycles, only %0d of %0d expected stores appeared",
                     cycles, storeIdx, expAddr.size());
            closeRun(1'b1);
        end
    end

endmodule

/* pipeLinks.sv */
// fetch/decode register contents
interface fetchLink;
    logic [pipePkg::dataW-1:0] instr;
    logic [pipePkg::dataW-1:0] pcPlus4;
    modport src (output instr, output pcPlus4);
    modport dst (input instr, input pcPlus4);
endinterface

// branch resolved in execute
interface branchLink;
    logic                      branchTaken;
    logic [pipePkg::dataW-1:0] branchTarget;
    modport src (output branchTaken, output branchTarget);
    modport dst (input branchTaken, input branchTarget);
endinterface

// decode/execute register contents
interface execLink;
    logic [2:0]                 aluOp;
    logic                       useImm;
    logic [pipePkg::dataW-1:0]  opA;
    logic [pipePkg::dataW-1:0]  opB;
    logic [pipePkg::dataW-1:0]  imm;
    logic [isaPkg::regIdxW-1:0] rs;
    logic [isaPkg::regIdxW-1:0] rt;
    logic [isaPkg::regIdxW-1:0] wsel;
    logic                       regWrite;
    logic                       memRead;
    logic                       memWrite;
    logic                       isBranch;
    logic [pipePkg::dataW-1:0]  pcPlus4;
    modport src (output aluOp, useImm, opA, opB, imm, rs, rt, wsel,
                 output regWrite, memRead, memWrite, isBranch, pcPlus4);
    modport dst (input aluOp, useImm, opA, opB, imm, rs, rt, wsel,
                 input regWrite, memRead, memWrite, isBranch, pcPlus4);
endinterface

// execute/memory register contents
interface memLink;
    logic [pipePkg::dataW-1:0]  aluResult;
    logic [pipePkg::dataW-1:0]  storeData;
    logic [isaPkg::regIdxW-1:0] wsel;
    logic                       regWrite;
    logic                       memRead;
    logic                       memWrite;
    modport src (output aluResult, storeData, wsel, regWrite, memRead, memWrite);
    modport dst (input aluResult, storeData, wsel, regWrite, memRead, memWrite);
endinterface

// register-file write port, also the writeback forward
interface wbLink;
    logic                       regWrite;
    logic [isaPkg::regIdxW-1:0] wsel;
    logic [pipePkg::dataW-1:0]  wdata;
    modport src (output regWrite, wsel, wdata);
    modport dst (input regWrite, wsel, wdata);
endinterface

/* pipePkg.sv */
package pipePkg;

    ////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////

    localparam int dataW     = 32;
    localparam int wordAddrW = 30;

    // alu operations
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr  = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;

    // operand source in execute
    localparam logic [1:0] fwdReg = 2'd0;
    localparam logic [1:0] fwdWb  = 2'd1;
    localparam logic [1:0] fwdMem = 2'd2;

    // write-back source
    localparam logic wbAlu = 1'b0;
    localparam logic wbMem = 1'b1;

endpackage

/* run.sh */
#!/usr/bin/env bash
# compile and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -f files.f --top-module mipsPipelineTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
[ -s sim.log ] || exit 1
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
